//--- Bender.yml
package:
  name: dsc_engine

sources:
  - logic/dsc_pkg.sv
  - logic/coef_shift_reg.sv
  - logic/dw_conv.sv
  - logic/pw_conv.sv
  - logic/dsc_ctrl.sv
  - logic/dsc_engine.sv
  - target: simulation
    files:
      - tb/tb_dsc.sv

//--- logic/coef_shift_reg.sv
// Coefficient shift bank
// Collects a stream of words into a parallel bank. Each load moves
// the bank down one slot and writes the new word into the top slot,
// so after DEPTH loads the first word sits in slot 0
`timescale 1ns/100ps
`default_nettype none

module coef_shift_reg #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  wire                          clk,
	input  wire                          load,
	input  wire  [WIDTH-1:0]             data_in,
	output logic [DEPTH-1:0][WIDTH-1:0]  bank
);

	always_ff @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < DEPTH - 1; i++) begin
				bank[i] <= bank[i+1];
			end
			bank[DEPTH-1] <= data_in;
		end
	end

endmodule

`default_nettype wire

//--- logic/dsc_ctrl.sv
// Depthwise-separable engine sequencer
// Accepts one command, loads the depthwise kernel once, then for each
// window loads the pixels, runs the depthwise stage and walks the
// output channels: pairs, optional partial sum, compute, write.
// All readies, res_valid, done and the datapath strobes come from here
`timescale 1ns/100ps
`default_nettype none

module dsc_ctrl #(
	parameter int NK   = 3,
	parameter int NPAR = 4,
	parameter int NNP  = 4
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 cmd_valid,
	output logic                cmd_ready,
	input  wire                 cmd_first,
	input  wire  dsc_pkg::cnt_t cmd_nwin,
	input  wire  dsc_pkg::cnt_t cmd_nof,
	input  wire                 dw_valid,
	output logic                dw_ready,
	input  wire                 px_valid,
	output logic                px_ready,
	input  wire                 pw_valid,
	output logic                pw_ready,
	input  wire                 psum_valid,
	output logic                psum_ready,
	output logic                res_valid,
	input  wire                 res_ready,
	output logic                done,
	output logic                dw_load,
	output logic                px_load,
	output logic                pw_load,
	output logic                dw_start,
	output logic                acc_clear,
	output logic                acc_load,
	output logic                pw_start
);

	import dsc_pkg::*;

	localparam int NWORD = NPAR * NK * NK;
	localparam int WC_W  = $clog2(NWORD > NNP ? NWORD : NNP) + 1;

	typedef enum logic [2:0] {
		IDLE,
		LOAD_DW,
		LOAD_PX,
		DW_WAIT,
		LOAD_PW,
		LOAD_PSUM,
		PW_CALC,
		WRITE
	} state_t;

	state_t           state;
	logic             first_q;
	cnt_t             nwin_q;
	cnt_t             nof_q;
	cnt_t             win_cnt;
	cnt_t             of_cnt;
	logic [WC_W-1:0]  word_cnt;
	logic             cmd_hs;
	logic             res_hs;
	logic             last_word;
	logic             last_pair;
	logic             last_win;
	logic             last_of;

	// Handshake side depends on state only
	assign cmd_ready  = (state == IDLE);
	assign dw_ready   = (state == LOAD_DW);
	assign px_ready   = (state == LOAD_PX);
	assign pw_ready   = (state == LOAD_PW);
	assign psum_ready = (state == LOAD_PSUM);
	assign res_valid  = (state == WRITE);

	assign cmd_hs   = cmd_valid & cmd_ready;
	assign res_hs   = res_valid & res_ready;
	assign dw_load  = dw_valid & dw_ready;
	assign px_load  = px_valid & px_ready;
	assign pw_load  = pw_valid & pw_ready;
	assign acc_load = psum_valid & psum_ready;

	// Base stays zero for the whole command
	assign acc_clear = cmd_hs & cmd_first;

	// First wait cycle, once the last pixel is in the bank
	assign dw_start = (state == DW_WAIT) && (word_cnt == '0);
	assign pw_start = (state == PW_CALC);

	assign last_word = (word_cnt == WC_W'(NWORD - 1));
	assign last_pair = (word_cnt == WC_W'(NNP - 1));
	assign last_win  = ((win_cnt + 1'b1) == nwin_q);
	assign last_of   = ((of_cnt + 1'b1) == nof_q);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= IDLE;
			first_q  <= 1'b0;
			nwin_q   <= '0;
			nof_q    <= '0;
			win_cnt  <= '0;
			of_cnt   <= '0;
			word_cnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (cmd_hs) begin
						first_q  <= cmd_first;
						nwin_q   <= cmd_nwin;
						nof_q    <= cmd_nof;
						win_cnt  <= '0;
						of_cnt   <= '0;
						word_cnt <= '0;
						state    <= LOAD_DW;
					end
				end
				LOAD_DW: begin
					if (dw_load) begin
						if (last_word) begin
							word_cnt <= '0;
							state    <= LOAD_PX;
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
					end
				end
				LOAD_PX: begin
					if (px_load) begin
						if (last_word) begin
							word_cnt <= '0;
							state    <= DW_WAIT;
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
					end
				end
				// Two cycles of depthwise pipeline latency
				DW_WAIT: begin
					if (word_cnt == WC_W'(1)) begin
						word_cnt <= '0;
						state    <= LOAD_PW;
					end else begin
						word_cnt <= word_cnt + 1'b1;
					end
				end
				LOAD_PW: begin
					if (pw_load) begin
						if (last_pair) begin
							word_cnt <= '0;
							state    <= first_q ? PW_CALC : LOAD_PSUM;
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
					end
				end
				LOAD_PSUM: begin
					if (acc_load)
						state <= PW_CALC;
				end
				PW_CALC: begin
					state <= WRITE;
				end
				WRITE: begin
					if (res_hs) begin
						if (!last_of) begin
							of_cnt <= of_cnt + 1'b1;
							state  <= LOAD_PW;
						end else begin
							of_cnt <= '0;
							if (last_win) begin
								done  <= 1'b1;
								state <= IDLE;
							end else begin
								// Kernel is kept, only pixels reload
								win_cnt <= win_cnt + 1'b1;
								state   <= LOAD_PX;
							end
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/dsc_engine.sv
// Depthwise-separable convolution engine, top level
// Streams in a depthwise kernel, window pixels, sparse pointwise pairs
// and optional partial sums, and streams out one result per output
// channel and window. Sets the kernel side, channel parallelism and
// pointwise pair count for all blocks below
`timescale 1ns/100ps
`default_nettype none

module dsc_engine #(
	parameter int NK   = 3,
	parameter int NPAR = 4,
	parameter int NNP  = 4
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 cmd_valid,
	output logic                cmd_ready,
	input  wire                 cmd_first,
	input  wire  dsc_pkg::cnt_t cmd_nwin,
	input  wire  dsc_pkg::cnt_t cmd_nof,
	input  wire                 dw_valid,
	output logic                dw_ready,
	input  wire  dsc_pkg::wg_t  dw_data,
	input  wire                 px_valid,
	output logic                px_ready,
	input  wire  dsc_pkg::px_t  px_data,
	input  wire                 pw_valid,
	output logic                pw_ready,
	input  wire  dsc_pkg::pos_t pw_pos,
	input  wire  dsc_pkg::wg_t  pw_weight,
	input  wire                 psum_valid,
	output logic                psum_ready,
	input  wire  dsc_pkg::px_t  psum_data,
	output logic                res_valid,
	input  wire                 res_ready,
	output dsc_pkg::px_t        res_data,
	output logic                done
);

	import dsc_pkg::*;

	localparam int NWORD  = NPAR * NK * NK;
	localparam int PAIR_W = $bits(pos_t) + WG_W;

	wg_t [NWORD-1:0]             dw_bank;
	px_t [NWORD-1:0]             px_bank;
	logic [NNP-1:0][PAIR_W-1:0]  pw_bank;
	px_t [NPAR-1:0]              act;

	logic dw_load;
	logic px_load;
	logic pw_load;
	logic dw_start;
	logic acc_clear;
	logic acc_load;
	logic pw_start;

	dsc_ctrl #(.NK(NK), .NPAR(NPAR), .NNP(NNP)) u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.cmd_first  (cmd_first),
		.cmd_nwin   (cmd_nwin),
		.cmd_nof    (cmd_nof),
		.dw_valid   (dw_valid),
		.dw_ready   (dw_ready),
		.px_valid   (px_valid),
		.px_ready   (px_ready),
		.pw_valid   (pw_valid),
		.pw_ready   (pw_ready),
		.psum_valid (psum_valid),
		.psum_ready (psum_ready),
		.res_valid  (res_valid),
		.res_ready  (res_ready),
		.done       (done),
		.dw_load    (dw_load),
		.px_load    (px_load),
		.pw_load    (pw_load),
		.dw_start   (dw_start),
		.acc_clear  (acc_clear),
		.acc_load   (acc_load),
		.pw_start   (pw_start)
	);

	coef_shift_reg #(.WIDTH(WG_W), .DEPTH(NWORD)) u_dw_bank (
		.clk     (clk),
		.load    (dw_load),
		.data_in (dw_data),
		.bank    (dw_bank)
	);

	coef_shift_reg #(.WIDTH(PX_W), .DEPTH(NWORD)) u_px_bank (
		.clk     (clk),
		.load    (px_load),
		.data_in (px_data),
		.bank    (px_bank)
	);

	// Position and weight share one bank slot
	coef_shift_reg #(.WIDTH(PAIR_W), .DEPTH(NNP)) u_pw_bank (
		.clk     (clk),
		.load    (pw_load),
		.data_in ({pw_pos, pw_weight}),
		.bank    (pw_bank)
	);

	dw_conv #(.NK(NK), .NPAR(NPAR)) u_dw_conv (
		.clk     (clk),
		.rst     (rst),
		.start   (dw_start),
		.pixels  (px_bank),
		.weights (dw_bank),
		.act     (act)
	);

	pw_conv #(.NPAR(NPAR), .NNP(NNP)) u_pw_conv (
		.clk       (clk),
		.rst       (rst),
		.act       (act),
		.pw_bank   (pw_bank),
		.psum_data (psum_data),
		.acc_clear (acc_clear),
		.acc_load  (acc_load),
		.start     (pw_start),
		.res_data  (res_data)
	);

endmodule

`default_nettype wire

//--- logic/dsc_pkg.sv
// Depthwise-separable convolution engine, shared definitions
// Fixed-point widths, the ReLU6 ceiling and the scalar types
// used by the datapath, the controller and the top level
`default_nettype none

package dsc_pkg;

	// Pixel and result format
	localparam int PX_W      = 16;
	localparam int FRAC_BITS = 12;

	// Weight format, the fraction bits are the product shift
	localparam int WG_W    = 8;
	localparam int WG_FRAC = 4;

	// Upper bound on channel parallelism
	localparam int MAX_NPAR = 8;

	typedef logic signed [PX_W-1:0] px_t;
	typedef logic signed [WG_W-1:0] wg_t;
	typedef logic [$clog2(MAX_NPAR)-1:0] pos_t;
	typedef logic [7:0] cnt_t;

	// 6.0 in pixel format
	localparam px_t RELU_MAX = px_t'(6 << FRAC_BITS);

endpackage

`default_nettype wire

//--- logic/dw_conv.sv
// Depthwise convolution datapath
// Stage one registers every pixel by weight product, truncated to
// pixel format. Stage two sums the NK x NK taps of each channel,
// clamps with ReLU6 and registers one activation per channel
`timescale 1ns/100ps
`default_nettype none

module dw_conv #(
	parameter int NK   = 3,
	parameter int NPAR = 4
) (
	input  wire                                   clk,
	input  wire                                   rst,
	input  wire                                   start,
	input  wire  dsc_pkg::px_t [NPAR*NK*NK-1:0]   pixels,
	input  wire  dsc_pkg::wg_t [NPAR*NK*NK-1:0]   weights,
	output dsc_pkg::px_t [NPAR-1:0]               act
);

	import dsc_pkg::*;

	localparam int NTAP  = NK * NK;
	localparam int NPROD = NPAR * NTAP;

	logic signed [PX_W+WG_W-1:0] full  [NPROD];
	px_t                         prod_q [NPROD];
	px_t                         sum    [NPAR];
	px_t                         relu   [NPAR];
	logic                        prod_vld;

	// Full precision products
	always_comb begin
		for (int i = 0; i < NPROD; i++) begin
			full[i] = $signed(pixels[i]) * $signed(weights[i]);
		end
	end

	// Arithmetic shift by WG_FRAC, then wrap to PX_W
	always_ff @(posedge clk) begin
		if (start) begin
			for (int i = 0; i < NPROD; i++) begin
				prod_q[i] <= full[i][WG_FRAC +: PX_W];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prod_vld <= 1'b0;
		end else begin
			prod_vld <= start;
		end
	end

	// Per-channel adder tree and clamp to [0, 6.0]
	always_comb begin
		for (int c = 0; c < NPAR; c++) begin
			sum[c] = '0;
			for (int t = 0; t < NTAP; t++) begin
				sum[c] = sum[c] + prod_q[c*NTAP + t];
			end
			if (sum[c] < 0)
				relu[c] = '0;
			else if (sum[c] >= RELU_MAX)
				relu[c] = RELU_MAX;
			else
				relu[c] = sum[c];
		end
	end

	always_ff @(posedge clk) begin
		if (prod_vld) begin
			for (int c = 0; c < NPAR; c++) begin
				act[c] <= relu[c];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/pw_conv.sv
// Sparse pointwise convolution
// Each of the NNP pairs picks one activation by position and scales
// it by its weight. The truncated products are added to a base value,
// which is zero or the incoming partial sum, and the total is registered
`timescale 1ns/100ps
`default_nettype none

module pw_conv #(
	parameter int NPAR = 4,
	parameter int NNP  = 4
) (
	input  wire                                                  clk,
	input  wire                                                  rst,
	input  wire  dsc_pkg::px_t [NPAR-1:0]                        act,
	input  wire  [NNP-1:0][$bits(dsc_pkg::pos_t)+dsc_pkg::WG_W-1:0] pw_bank,
	input  wire  dsc_pkg::px_t                                   psum_data,
	input  wire                                                  acc_clear,
	input  wire                                                  acc_load,
	input  wire                                                  start,
	output dsc_pkg::px_t                                         res_data
);

	import dsc_pkg::*;

	localparam int POS_W = $bits(pos_t);

	px_t base_q;
	px_t total;

	// Zero for a first input-channel group, else the partial sum
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			base_q <= '0;
		end else if (acc_clear) begin
			base_q <= '0;
		end else if (acc_load) begin
			base_q <= psum_data;
		end
	end

	// Pair layout is position above weight
	always_comb begin : pw_sum
		pos_t                        pos;
		wg_t                         wgt;
		px_t                         sel;
		logic signed [PX_W+WG_W-1:0] full;

		total = base_q;
		for (int n = 0; n < NNP; n++) begin
			pos = pw_bank[n][WG_W +: POS_W];
			wgt = pw_bank[n][WG_W-1:0];
			// Positions beyond NPAR select nothing
			sel = (pos < NPAR) ? act[pos] : '0;
			full = sel * wgt;
			total = total + full[WG_FRAC +: PX_W];
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			res_data <= total;
		end
	end

endmodule

`default_nettype wire

//--- project.f
logic/dsc_pkg.sv
logic/coef_shift_reg.sv
logic/dw_conv.sv
logic/pw_conv.sv
logic/dsc_ctrl.sv
logic/dsc_engine.sv
tb/tb_dsc.sv

//--- tb/tb_dsc.sv
// Depthwise-separable engine testbench
// Random commands, kernels, windows, pointwise pairs and partial sums
// with random input gaps and result back-pressure. Expected results
// come from an integer model and are compared in order at each result
`timescale 1ns/100ps
`default_nettype none

module tb_dsc;

	import dsc_pkg::*;

	localparam int NK = 3;
	localparam int NPAR = 4;
	localparam int NNP = 4;
	localparam int NTAP = NK * NK;
	localparam int NWORD = NPAR * NTAP;
	localparam int NCMD = 8;
	// Longest command is three windows of four output channels
	localparam int MAX_WORDS = NWORD + 3 * (NWORD + 4 * (NNP + 2));
	localparam int TIMEOUT_NS = NCMD * MAX_WORDS * 4 * 8;

	logic clk, rst;
	logic cmd_valid, cmd_ready, cmd_first;
	cnt_t cmd_nwin, cmd_nof;
	logic dw_valid, dw_ready, px_valid, px_ready, pw_valid, pw_ready;
	logic psum_valid, psum_ready, res_valid, res_ready, done;
	wg_t dw_data, pw_weight;
	px_t px_data, psum_data, res_data;
	pos_t pw_pos;

	logic [31:0] drv_st, snk_st;
	int mis_cnt, err_cnt, res_cnt, exp_total, psum_cnt;
	int dw_cnt, done_cnt;
	bit busy, cur_first, first, bias, waiting;
	int nwin, nof;
	px_t exp_q[$];
	wg_t w_m[NWORD];
	px_t p_m[NWORD];
	px_t act_m[NPAR];
	pos_t pos_m[NNP];
	wg_t pwt_m[NNP];
	px_t ps, acc_m, sum_m, held, expv;

	dsc_engine #(.NK(NK), .NPAR(NPAR), .NNP(NNP)) UUT (
		.clk(clk), .rst(rst),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_first(cmd_first),
		.cmd_nwin(cmd_nwin), .cmd_nof(cmd_nof),
		.dw_valid(dw_valid), .dw_ready(dw_ready), .dw_data(dw_data),
		.px_valid(px_valid), .px_ready(px_ready), .px_data(px_data),
		.pw_valid(pw_valid), .pw_ready(pw_ready), .pw_pos(pw_pos), .pw_weight(pw_weight),
		.psum_valid(psum_valid), .psum_ready(psum_ready), .psum_data(psum_data),
		.res_valid(res_valid), .res_ready(res_ready), .res_data(res_data), .done(done)
	);

	always #2 clk = ~clk;

	// LCG step, separate state for the stimulus and the result sink
	function automatic int pick(input bit sink, input int n);
		if (sink) begin
			snk_st = snk_st * 32'd1664525 + 32'd1013904223;
			return int'((snk_st >> 8) % n);
		end
		drv_st = drv_st * 32'd1664525 + 32'd1013904223;
		return int'((drv_st >> 8) % n);
	endfunction

	// Truncated fixed-point product
	function automatic px_t scale_product(input px_t p, input wg_t w);
		int full;
		full = int'(p) * int'(w);
		return px_t'(full >>> WG_FRAC);
	endfunction

	function automatic px_t relu6(input px_t s);
		if (s < 0)
			return '0;
		if (s >= px_t'(6 << FRAC_BITS))
			return px_t'(6 << FRAC_BITS);
		return s;
	endfunction

	task automatic set_valid(input int s, input logic v);
		case (s)
			0: cmd_valid = v;
			1: dw_valid = v;
			2: px_valid = v;
			3: pw_valid = v;
			default: psum_valid = v;
		endcase
	endtask

	// Offer one word on stream s, with an occasional gap first
	task automatic handshake(input int s);
		bit taken;
		if (pick(0, 4) == 0) begin
			repeat (1 + pick(0, 3)) begin
				@(posedge clk);
				#0.5;
			end
		end
		set_valid(s, 1'b1);
		taken = 0;
		while (!taken) begin
			@(negedge clk);
			case (s)
				0: taken = cmd_ready;
				1: taken = dw_ready;
				2: taken = px_ready;
				3: taken = pw_ready;
				default: taken = psum_ready;
			endcase
			@(posedge clk);
			#0.5;
		end
		set_valid(s, 1'b0);
	endtask

	task automatic report_counts();
		$display("Results %0d of %0d, %0d mismatches, %0d other errors",
			res_cnt, exp_total, mis_cnt, err_cnt);
	endtask

	// Protocol monitor, sampled mid-cycle where outputs are stable
	always @(negedge clk) begin
		if (!rst) begin
			if (done) begin
				if (!busy) begin
					err_cnt++;
					$display("ERROR: done pulsed with no command in flight");
				end
				if (exp_q.size() != 0) begin
					err_cnt++;
					$display("ERROR: done pulsed before all results were delivered");
				end
				done_cnt++;
				busy = 0;
			end
			if (busy && cmd_ready) begin
				err_cnt++;
				$display("ERROR: cmd_ready high while a command was in flight");
			end
			if (res_valid && (cmd_ready || dw_ready || px_ready || pw_ready || psum_ready)) begin
				err_cnt++;
				$display("ERROR: an input ready was high while res_valid waited");
			end
			if (psum_ready && cur_first) begin
				err_cnt++;
				$display("ERROR: psum_ready raised for a command without partial sums");
			end
			// The kernel is loaded once per command
			if (dw_ready && dw_cnt == NWORD) begin
				err_cnt++;
				$display("ERROR: dw_ready raised again after the kernel was loaded");
			end
			if (cmd_valid && cmd_ready) begin
				busy = 1;
				cur_first = cmd_first;
				dw_cnt = 0;
			end
			if (dw_valid && dw_ready)
				dw_cnt++;
			if (psum_valid && psum_ready)
				psum_cnt++;
			// One partial sum per output channel, none for a first group
			if (res_valid && res_ready) begin
				if (psum_cnt != (cur_first ? 0 : 1)) begin
					err_cnt++;
					$display("ERROR: %0d partial sums taken for one output channel",
						psum_cnt);
				end
				psum_cnt = 0;
			end
		end
	end

	// Result sink with random back-pressure
	initial begin
		@(negedge rst);
		forever begin
			@(posedge clk);
			#0.5;
			res_ready = (pick(1, 4) != 0);
			@(negedge clk);
			if (res_valid && waiting && res_data !== held) begin
				err_cnt++;
				$display("ERROR: res_data changed while res_valid waited");
			end
			if (res_valid && res_ready) begin
				waiting = 0;
				if (exp_q.size() == 0) begin
					err_cnt++;
					$display("ERROR: a result arrived with no expected value left");
				end else begin
					expv = exp_q.pop_front();
					if (res_data !== expv) begin
						mis_cnt++;
						$display("MISMATCH res_data: got %h expected %h (result %0d)",
							res_data, expv, res_cnt);
					end
				end
				res_cnt++;
			end else if (res_valid) begin
				waiting = 1;
				held = res_data;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("ERROR: timeout, the run did not finish within %0d ns", TIMEOUT_NS);
		report_counts();
		$display("Finished with errors");
		$finish;
	end

	initial begin
		clk = 0;
		rst = 1;
		drv_st = 32'h801079f6;
		snk_st = ~32'h801079f6;
		{cmd_valid, cmd_first, dw_valid, px_valid, pw_valid, psum_valid, res_ready} = '0;
		{cmd_nwin, cmd_nof, dw_data, px_data, pw_pos, pw_weight, psum_data} = '0;
		repeat (2) @(posedge clk);
		#0.5;
		rst = 0;
		@(negedge clk);
		if (!cmd_ready || dw_ready || px_ready || pw_ready || psum_ready || res_valid || done) begin
			err_cnt++;
			$display("ERROR: handshake outputs after reset are not idle");
		end
		@(posedge clk);
		#0.5;
		for (int k = 0; k < NCMD; k++) begin
			first = (k % 2 == 0);
			// Commands 4 and 5 push activations past both clamp limits
			bias = (k == 4 || k == 5);
			nwin = (k >= 6) ? 3 : 1 + pick(0, 2);
			nof = 1 + pick(0, 4);
			cmd_first = first;
			cmd_nwin = cnt_t'(nwin);
			cmd_nof = cnt_t'(nof);
			handshake(0);
			for (int i = 0; i < NWORD; i++) begin
				w_m[i] = wg_t'(pick(0, 64) - 32);
				dw_data = w_m[i];
				handshake(1);
			end
			for (int win = 0; win < nwin; win++) begin
				for (int i = 0; i < NWORD; i++) begin
					if (bias)
						p_m[i] = px_t'(pick(0, 2) ? 24576 + pick(0, 8192)
							: -24576 - pick(0, 8192));
					else
						p_m[i] = px_t'(pick(0, 16384) - 8192);
					px_data = p_m[i];
					handshake(2);
				end
				for (int c = 0; c < NPAR; c++) begin
					sum_m = '0;
					for (int t = 0; t < NTAP; t++)
						sum_m = sum_m + scale_product(p_m[c*NTAP + t], w_m[c*NTAP + t]);
					act_m[c] = relu6(sum_m);
				end
				for (int o = 0; o < nof; o++) begin
					ps = px_t'(pick(0, 65536));
					acc_m = first ? px_t'(0) : ps;
					for (int n = 0; n < NNP; n++) begin
						pos_m[n] = pos_t'(pick(0, NPAR));
						pwt_m[n] = wg_t'(pick(0, 256) - 128);
						acc_m = acc_m + scale_product(act_m[pos_m[n]], pwt_m[n]);
					end
					exp_q.push_back(acc_m);
					exp_total++;
					for (int n = 0; n < NNP; n++) begin
						pw_pos = pos_m[n];
						pw_weight = pwt_m[n];
						handshake(3);
					end
					if (!first) begin
						psum_data = ps;
						handshake(4);
					end
				end
			end
		end
		wait (done_cnt == NCMD);
		repeat (4) @(posedge clk);
		if (res_cnt != exp_total) begin
			err_cnt++;
			$display("ERROR: %0d results delivered, %0d expected", res_cnt, exp_total);
		end
		report_counts();
		if (mis_cnt == 0 && err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
